/* bench/tb_adc_xy_display.sv */
`timescale 1ns/1ns

module tb_adc_xy_display
  import adc_xy_pkg::*;
();

  localparam int ADC_BITS = 10;
  localparam int FB_W = 64;
  localparam int FB_H = 48;
  localparam int H_TOT = FB_W + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOT = FB_H + V_FRONT + V_SYNC + V_BACK;
  // scanout idles for the start delay, then one register stage
  localparam int FIRST_DE = SCAN_START_DELAY + 1;
  localparam int CYCLE_LIMIT = 20 * H_TOT * V_TOT + 4000;

  logic                clk;
  logic                rst;
  logic [ADC_BITS-1:0] adc_x;
  logic [ADC_BITS-1:0] adc_y;
  logic                adc_strobe;
  logic                clear;
  color_t              vga_red;
  color_t              vga_grn;
  color_t              vga_blu;
  logic                vga_hsync;
  logic                vga_vsync;
  logic                vga_de;
  logic                clear_busy;

  int          seed;
  int          cycles = 0;
  int          cyc = 0;
  int          busy_left = 0;
  int          px = 0;
  int          py = 0;
  int          t;
  int          h;
  int          v;
  int          mx;
  int          my;
  logic        started = 1'b0;
  logic        frame_ok = 1'b0;
  logic        vs_d = 1'b1;
  logic        white [FB_W*FB_H];
  logic        exp_de;
  logic        exp_hs;
  logic        exp_vs;
  logic [11:0] exp_rgb;

  adc_xy_display u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    stop_run($sformatf("mismatch at %0t: %s expected %0h, actual %0h",
                       $time, name, expected, actual));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      stop_run("timeout: the display did not get through its frames in time");
    end
  end

  // scaled adc position, shift down to the coordinate widths
  assign mx = int'(adc_x) >> (ADC_BITS - 7);
  assign my = int'(adc_y) >> (ADC_BITS - 6);

  always @(posedge clk) begin
    started <= 1'b1;
    vs_d <= vga_vsync;
    cyc <= rst ? 0 : cyc + 1;
    // sweep covers every pixel once
    if (rst || clear) begin
      busy_left <= FB_W * FB_H;
    end else if (busy_left > 0) begin
      busy_left <= busy_left - 1;
    end
    // only frames with no sweep running are compared pixel by pixel
    if (busy_left != 0) begin
      frame_ok <= 1'b0;
    end else if (vs_d && !vga_vsync) begin
      frame_ok <= 1'b1;
    end
    // scan position from de runs
    if (vga_de) begin
      px <= px + 1;
    end else begin
      px <= 0;
      if (px != 0) begin
        py <= py + 1;
      end
    end
    if (vs_d && !vga_vsync) begin
      py <= 0;
    end
    // reference picture, points lost while the sweep owns the buffer
    if (rst || clear) begin
      for (int i = 0; i < FB_W * FB_H; i++) begin
        white[i] <= 1'b0;
      end
    end else if (adc_strobe && busy_left <= 1 && mx < FB_W && my < FB_H) begin
      white[my * FB_W + mx] <= 1'b1;
    end
  end

  always_comb begin
    t = cyc - FIRST_DE;
    h = t % H_TOT;
    v = (t / H_TOT) % V_TOT;
    exp_de = (t >= 0) && (h < FB_W) && (v < FB_H);
    exp_hs = !((t >= 0) && (h >= FB_W + H_FRONT) && (h < FB_W + H_FRONT + H_SYNC));
    exp_vs = !((t >= 0) && (v >= FB_H + V_FRONT) && (v < FB_H + V_FRONT + V_SYNC));
    exp_rgb = (vga_de && white[py * FB_W + px]) ? 12'hfff : 12'h000;
  end

  // outputs settle after the rising edge, compare at the falling one
  assert property (@(negedge clk) disable iff (!started) clear_busy == (busy_left != 0))
    else report_mismatch("clear_busy", busy_left != 0, clear_busy);
  assert property (@(negedge clk) disable iff (!started) vga_de == exp_de)
    else report_mismatch("vga_de", exp_de, vga_de);
  assert property (@(negedge clk) disable iff (!started) vga_hsync == exp_hs)
    else report_mismatch("vga_hsync", exp_hs, vga_hsync);
  assert property (@(negedge clk) disable iff (!started) vga_vsync == exp_vs)
    else report_mismatch("vga_vsync", exp_vs, vga_vsync);
  assert property (@(negedge clk) disable iff (!started)
                   (vga_de && !frame_ok) || {vga_red, vga_grn, vga_blu} == exp_rgb)
    else report_mismatch("vga_rgb", exp_rgb, {vga_red, vga_grn, vga_blu});

  task automatic wait_vsync_fall();
    @(negedge clk);
    while (!vga_vsync) @(negedge clk);
    while (vga_vsync) @(negedge clk);
  endtask

  task automatic plot(input int x, input int y);
    @(negedge clk);
    adc_x = ADC_BITS'(x);
    adc_y = ADC_BITS'(y);
    adc_strobe = 1'b1;
    @(negedge clk);
    adc_strobe = 1'b0;
  endtask

  task automatic pulse_clear();
    @(negedge clk);
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
  endtask

  initial begin
    seed = 41642;
    rst = 1'b1;
    adc_x = '0;
    adc_y = '0;
    adc_strobe = 1'b0;
    clear = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // startup sweep, then a frame that has to be black
    repeat (2) wait_vsync_fall();
    // points go in during vertical blanking
    repeat (5) plot($unsigned($random(seed)) % 512, $unsigned($random(seed)) % 768);
    // scaled y lands below the last row
    plot($unsigned($random(seed)) % 512, 768 + $unsigned($random(seed)) % 256);
    repeat (2) wait_vsync_fall();
    pulse_clear();
    // late in the sweep, on a row it has already blanked
    repeat (FB_W * FB_H - 200) @(negedge clk);
    plot($unsigned($random(seed)) % 512, $unsigned($random(seed)) % 640);
    repeat (3) wait_vsync_fall();
    plot($unsigned($random(seed)) % 512, $unsigned($random(seed)) % 768);
    repeat (2) wait_vsync_fall();
    $display("All checks passed");
    $finish;
  end

endmodule

/* build.f */
src/adc_xy_pkg.sv
src/adc_sampler.sv
src/fb_clear.sv
src/frame_store.sv
src/vga_scanout.sv
src/adc_xy_display.sv
bench/tb_adc_xy_display.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_adc_xy_display -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* src/adc_sampler.sv */
`timescale 1ns/1ns

module adc_sampler
  import adc_xy_pkg::*;
#(
  parameter int ADC_BITS = 10,
  parameter int FB_WIDTH = 64,
  parameter int FB_HEIGHT = 48
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADC_BITS-1:0] adc_x,
  input  logic [ADC_BITS-1:0] adc_y,
  input  logic                adc_strobe,
  output plot_point_t         point
);

  // drop the low adc bits down to frame coordinate width
  localparam int X_SHIFT = ADC_BITS - $bits(fb_x_t);
  localparam int Y_SHIFT = ADC_BITS - $bits(fb_y_t);

  logic [ADC_BITS-1:0] x_scaled;
  logic [ADC_BITS-1:0] y_scaled;
  logic                in_frame;

  assign x_scaled = adc_x >> X_SHIFT;
  assign y_scaled = adc_y >> Y_SHIFT;

  // y can land past the bottom row when the frame is not a power of two
  assign in_frame = (x_scaled < ADC_BITS'(FB_WIDTH)) && (y_scaled < ADC_BITS'(FB_HEIGHT));

  always_ff @(posedge clk) begin
    if (adc_strobe) begin
      point.x <= fb_x_t'(x_scaled);
      point.y <= fb_y_t'(y_scaled);
    end
    // valid is a single-cycle pulse
    if (rst) begin
      point.valid <= 1'b0;
    end else begin
      point.valid <= adc_strobe && in_frame;
    end
  end

endmodule

/* src/adc_xy_display.sv */
`timescale 1ns/1ns

module adc_xy_display
  import adc_xy_pkg::*;
#(
  parameter int ADC_BITS = 10,
  parameter int FB_WIDTH = 64,
  parameter int FB_HEIGHT = 48
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADC_BITS-1:0] adc_x,
  input  logic [ADC_BITS-1:0] adc_y,
  input  logic                adc_strobe,
  input  logic                clear,
  output color_t              vga_red,
  output color_t              vga_grn,
  output color_t              vga_blu,
  output logic                vga_hsync,
  output logic                vga_vsync,
  output logic                vga_de,
  output logic                clear_busy
);

  plot_point_t  point;
  clear_sweep_t sweep;
  fb_x_t        rd_x;
  fb_y_t        rd_y;
  pixel_t       rd_pixel;

  adc_sampler #(
    .ADC_BITS (ADC_BITS),
    .FB_WIDTH (FB_WIDTH),
    .FB_HEIGHT(FB_HEIGHT)
  ) u_sampler (
    .clk       (clk),
    .rst       (rst),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_strobe(adc_strobe),
    .point     (point)
  );

  fb_clear #(
    .FB_WIDTH (FB_WIDTH),
    .FB_HEIGHT(FB_HEIGHT)
  ) u_clear (
    .clk  (clk),
    .rst  (rst),
    .clear(clear),
    .sweep(sweep)
  );

  frame_store #(
    .FB_WIDTH (FB_WIDTH),
    .FB_HEIGHT(FB_HEIGHT)
  ) u_store (
    .clk     (clk),
    .sweep   (sweep),
    .point   (point),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .rd_pixel(rd_pixel)
  );

  vga_scanout #(
    .FB_WIDTH (FB_WIDTH),
    .FB_HEIGHT(FB_HEIGHT)
  ) u_scan (
    .clk      (clk),
    .rst      (rst),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_pixel (rd_pixel),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

  assign clear_busy = sweep.active;

endmodule

/* src/adc_xy_pkg.sv */
package adc_xy_pkg;

  // frame coordinates, sized for up to 128 x 64
  typedef logic [6:0] fb_x_t;
  typedef logic [5:0] fb_y_t;

  // stored pixel is 4:4:4 rgb
  typedef logic [11:0] pixel_t;
  typedef logic [3:0] color_t;

  // one scaled adc point, valid for a single cycle
  typedef struct packed {
    fb_x_t x;
    fb_y_t y;
    logic  valid;
  } plot_point_t;

  // current clear sweep position
  typedef struct packed {
    fb_x_t x;
    fb_y_t y;
    logic  active;
  } clear_sweep_t;

  // horizontal blanking, in pixels after the active area
  localparam int H_FRONT = 2;
  localparam int H_SYNC = 4;
  localparam int H_BACK = 2;

  // vertical blanking, in lines after the active area
  localparam int V_FRONT = 1;
  localparam int V_SYNC = 2;
  localparam int V_BACK = 1;

  // cycles the scanout holds off after reset
  localparam int SCAN_START_DELAY = 8;

  localparam pixel_t PLOT_COLOR = '1;
  localparam pixel_t CLEAR_COLOR = '0;

endpackage

/* src/fb_clear.sv */
`timescale 1ns/1ns

module fb_clear
  import adc_xy_pkg::*;
#(
  parameter int FB_WIDTH = 64,
  parameter int FB_HEIGHT = 48
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         clear,
  output clear_sweep_t sweep
);

  localparam fb_x_t X_LAST = fb_x_t'(FB_WIDTH - 1);
  localparam fb_y_t Y_LAST = fb_y_t'(FB_HEIGHT - 1);

  logic last_col;
  logic last_row;

  assign last_col = (sweep.x == X_LAST);
  assign last_row = (sweep.y == Y_LAST);

  // one pixel per clock, row by row
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      // a clear mid-sweep starts over from the top left
      sweep.active <= 1'b1;
      sweep.x <= '0;
      sweep.y <= '0;
    end else if (sweep.active) begin
      if (last_col) begin
        sweep.x <= '0;
        if (last_row) begin
          sweep.y <= '0;
          sweep.active <= 1'b0;
        end else begin
          sweep.y <= sweep.y + 1'b1;
        end
      end else begin
        sweep.x <= sweep.x + 1'b1;
      end
    end
  end

endmodule

/* src/frame_store.sv */
`timescale 1ns/1ns

module frame_store
  import adc_xy_pkg::*;
#(
  parameter int FB_WIDTH = 64,
  parameter int FB_HEIGHT = 48
) (
  input  logic         clk,
  input  clear_sweep_t sweep,
  input  plot_point_t  point,
  input  fb_x_t        rd_x,
  input  fb_y_t        rd_y,
  output pixel_t       rd_pixel
);

  localparam int DEPTH = FB_WIDTH * FB_HEIGHT;
  localparam int ADDR_BITS = $clog2(DEPTH);

  typedef logic [ADDR_BITS-1:0] fb_addr_t;

  // one write request into the buffer
  typedef struct packed {
    fb_x_t  x;
    fb_y_t  y;
    pixel_t color;
    logic   en;
  } fb_write_t;

  pixel_t    mem [DEPTH];
  fb_write_t wr;

  // row-major, y times width plus x
  function automatic fb_addr_t addr_of(input fb_x_t x, input fb_y_t y);
    return fb_addr_t'(y) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(x);
  endfunction

  // the sweep owns the write port while active, points are lost
  always_comb begin
    if (sweep.active) begin
      wr.x = sweep.x;
      wr.y = sweep.y;
      wr.color = CLEAR_COLOR;
      wr.en = 1'b1;
    end else begin
      wr.x = point.x;
      wr.y = point.y;
      wr.color = PLOT_COLOR;
      wr.en = point.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[addr_of(wr.x, wr.y)] <= wr.color;
    end
  end

  // scanout port, one cycle latency
  always_ff @(posedge clk) begin
    rd_pixel <= mem[addr_of(rd_x, rd_y)];
  end

endmodule

/* src/vga_scanout.sv */
`timescale 1ns/1ns

module vga_scanout
  import adc_xy_pkg::*;
#(
  parameter int FB_WIDTH = 64,
  parameter int FB_HEIGHT = 48
) (
  input  logic   clk,
  input  logic   rst,
  output fb_x_t  rd_x,
  output fb_y_t  rd_y,
  input  pixel_t rd_pixel,
  output color_t vga_red,
  output color_t vga_grn,
  output color_t vga_blu,
  output logic   vga_hsync,
  output logic   vga_vsync,
  output logic   vga_de
);

  localparam int H_TOTAL = FB_WIDTH + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = FB_HEIGHT + V_FRONT + V_SYNC + V_BACK;
  localparam int H_BITS = $clog2(H_TOTAL);
  localparam int V_BITS = $clog2(V_TOTAL);
  localparam int DELAY_BITS = $clog2(SCAN_START_DELAY);

  // sync windows follow the front porch
  localparam int H_SYNC_START = FB_WIDTH + H_FRONT;
  localparam int V_SYNC_START = FB_HEIGHT + V_FRONT;

  typedef enum logic {
    SCAN_WAIT,
    SCAN_RUN
  } scan_state_t;

  scan_state_t           state;
  logic [DELAY_BITS-1:0] delay_cnt;
  logic [H_BITS-1:0]     h_cnt;
  logic [V_BITS-1:0]     v_cnt;
  logic                  running;
  logic                  visible;
  logic                  hsync_now;
  logic                  vsync_now;
  pixel_t                pixel_out;

  // hold off so the clear sweep gets going first
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SCAN_WAIT;
      delay_cnt <= '0;
    end else begin
      case (state)
        SCAN_WAIT: begin
          if (delay_cnt == DELAY_BITS'(SCAN_START_DELAY - 1)) begin
            state <= SCAN_RUN;
          end
          delay_cnt <= delay_cnt + 1'b1;
        end
        default: state <= SCAN_RUN;
      endcase
    end
  end

  assign running = (state == SCAN_RUN);

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (running) begin
      if (h_cnt == H_BITS'(H_TOTAL - 1)) begin
        h_cnt <= '0;
        if (v_cnt == V_BITS'(V_TOTAL - 1)) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // active area sits at the start of each line and frame
  assign visible = running && (h_cnt < H_BITS'(FB_WIDTH)) && (v_cnt < V_BITS'(FB_HEIGHT));

  assign hsync_now = !(running && (h_cnt >= H_BITS'(H_SYNC_START))
                       && (h_cnt < H_BITS'(H_SYNC_START + H_SYNC)));
  assign vsync_now = !(running && (v_cnt >= V_BITS'(V_SYNC_START))
                       && (v_cnt < V_BITS'(V_SYNC_START + V_SYNC)));

  // counters are the read address, parked at 0 in blanking
  assign rd_x = visible ? fb_x_t'(h_cnt) : '0;
  assign rd_y = visible ? fb_y_t'(v_cnt) : '0;

  // one stage to meet the read data
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_de <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vga_de <= visible;
      vga_hsync <= hsync_now;
      vga_vsync <= vsync_now;
    end
  end

  // black outside the visible area
  assign pixel_out = vga_de ? rd_pixel : '0;

  assign vga_red = pixel_out[11:8];
  assign vga_grn = pixel_out[7:4];
  assign vga_blu = pixel_out[3:0];

endmodule
